/* verilog.f */
+incdir+hw
hw/cpu_pkg.sv
hw/pc_counter.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/execute_unit.sv
hw/riscv_cpu.sv
testbench/result_checker.sv
testbench/tb_riscv_cpu.sv

/* testbench/tb_riscv_cpu.sv */
`include "cpu_settings.svh"

module tb_riscv_cpu;

    localparam int NUM_TESTS  = 6;
    localparam int PROG_WORDS = 16;
    localparam int IMEM_WORDS = 32;
    localparam int DMEM_WORDS = 16;
    localparam int TIME_LIMIT = NUM_TESTS * (PROG_WORDS + 20) * 40;
    localparam logic [31:0] EBREAK_INSTR = {12'd1, 5'd0, 3'b000, 5'd0, `CPU_OP_SYSTEM};

    // one row of the stimulus table
    typedef struct packed {
        logic [PROG_WORDS-1:0][31:0] prog;
        logic [31:0]                 preload;      // data word at 0x10
        logic [31:0]                 exp_addr;     // final store
        logic [31:0]                 exp_value;
        logic [7:0]                  exp_stores;   // stores expected in total
    } test_row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr, imem_data;
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic        dmem_wr_en;
    logic        halt;
    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    test_row_t   rows [0:NUM_TESTS-1];
    logic [31:0] rng = 32'd60;                      // xorshift state
    int          test_idx;
    logic [31:0] exp_addr, exp_value;
    logic [7:0]  exp_stores;
    logic        checked;
    int          pass_count, fail_count;

    always #20 clk = ~clk;                          // 40 unit period

    riscv_cpu riscv_cpu_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wr_en (dmem_wr_en),
        .dmem_rdata (dmem_rdata),
        .halt       (halt)
    );

    result_checker result_checker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt       (halt),
        .imem_addr  (imem_addr),
        .dmem_wr_en (dmem_wr_en),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .test_idx   (test_idx),
        .exp_addr   (exp_addr),
        .exp_value  (exp_value),
        .exp_stores (exp_stores),
        .checked    (checked),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // ====================
    // memory models
    assign imem_data  = (imem_addr[31:2] < IMEM_WORDS) ? imem[imem_addr[6:2]] : `CPU_NOP_INSTR;
    assign dmem_rdata = dmem[dmem_addr[5:2]];       // combinational read

    always @(posedge clk) begin
        if (dmem_wr_en) dmem[dmem_addr[5:2]] <= dmem_wdata;
    end

    // ====================
    // instruction encoders
    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, `CPU_OP_REG};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, `CPU_F3_ADD, rd, `CPU_OP_IMM};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, `CPU_F3_WORD, rd, `CPU_OP_LOAD};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `CPU_F3_WORD, imm[4:0], `CPU_OP_STORE};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `CPU_OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `CPU_OP_JAL};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic test_row_t blank_row();
        test_row_t r;
        r = '0;
        for (int i = 0; i < PROG_WORDS; i++) r.prog[i] = `CPU_NOP_INSTR;
        return r;
    endfunction

    // ====================
    // stimulus table with expected values from isa arithmetic
    task automatic build_table();
        test_row_t   r;
        logic [11:0] a, b;
        logic [31:0] v [1:9];
        // row 0 is a dependent alu chain forwarding from mem and wb into execute
        rng = xorshift32(rng);
        a = rng[11:0];
        rng = xorshift32(rng);
        b = rng[11:0];
        r = blank_row();
        r.prog[0]  = addi(5'd1, 5'd0, a);
        r.prog[1]  = addi(5'd2, 5'd0, b);
        r.prog[2]  = alu_rr(7'd0, `CPU_F3_ADD, 5'd3, 5'd1, 5'd2);
        r.prog[3]  = alu_rr(`CPU_F7_SUB, `CPU_F3_ADD, 5'd4, 5'd3, 5'd1);
        r.prog[4]  = alu_rr(7'd0, `CPU_F3_XOR, 5'd5, 5'd4, 5'd3);
        r.prog[5]  = alu_rr(7'd0, `CPU_F3_AND, 5'd6, 5'd5, 5'd2);
        r.prog[6]  = alu_rr(7'd0, `CPU_F3_OR, 5'd7, 5'd6, 5'd4);
        r.prog[7]  = alu_rr(7'd0, `CPU_F3_SLT, 5'd8, 5'd7, 5'd5);
        r.prog[8]  = alu_rr(7'd0, `CPU_F3_ADD, 5'd9, 5'd7, 5'd8);
        r.prog[9]  = sw(5'd9, 5'd0, 12'h020);
        r.prog[10] = EBREAK_INSTR;
        v[1] = sext12(a);
        v[2] = sext12(b);
        v[3] = v[1] + v[2];
        v[4] = v[3] - v[1];
        v[5] = v[4] ^ v[3];
        v[6] = v[5] & v[2];
        v[7] = v[6] | v[4];
        v[8] = ($signed(v[7]) < $signed(v[5])) ? 32'd1 : 32'd0;
        v[9] = v[7] + v[8];
        r.exp_addr   = 32'h20;
        r.exp_value  = v[9];
        r.exp_stores = 8'd1;
        rows[0] = r;
        // row 1 loads a word and uses it in the very next instruction
        rng = xorshift32(rng);
        a = rng[11:0];
        rng = xorshift32(rng);
        r = blank_row();
        r.preload = rng;
        r.prog[0] = addi(5'd2, 5'd0, a);
        r.prog[1] = lw(5'd1, 5'd0, 12'h010);
        r.prog[2] = alu_rr(7'd0, `CPU_F3_ADD, 5'd3, 5'd1, 5'd2);
        r.prog[3] = sw(5'd3, 5'd0, 12'h024);
        r.prog[4] = EBREAK_INSTR;
        r.exp_addr   = 32'h24;
        r.exp_value  = r.preload + sext12(a);
        r.exp_stores = 8'd1;
        rows[1] = r;
        // row 2 reads three slots behind the writer through the decode bypass
        rng = xorshift32(rng);
        a = rng[11:0];
        r = blank_row();
        r.prog[0] = addi(5'd1, 5'd0, a);
        r.prog[1] = addi(5'd5, 5'd0, 12'd1);
        r.prog[2] = addi(5'd6, 5'd0, 12'd2);
        r.prog[3] = alu_rr(7'd0, `CPU_F3_ADD, 5'd2, 5'd1, 5'd1);
        r.prog[4] = addi(5'd7, 5'd0, 12'd3);
        r.prog[5] = addi(5'd8, 5'd0, 12'd4);
        r.prog[6] = sw(5'd2, 5'd0, 12'h028);
        r.prog[7] = EBREAK_INSTR;
        r.exp_addr   = 32'h28;
        r.exp_value  = sext12(a) + sext12(a);
        r.exp_stores = 8'd1;
        rows[2] = r;
        // row 3 has a taken beq that jumps over two stores
        rng = xorshift32(rng);
        a = rng[11:0];
        r = blank_row();
        r.prog[0] = addi(5'd1, 5'd0, a);
        r.prog[1] = addi(5'd2, 5'd0, a);
        r.prog[2] = branch(`CPU_F3_BEQ, 5'd1, 5'd2, 13'd12);   // to word 5
        r.prog[3] = sw(5'd1, 5'd0, 12'h030);
        r.prog[4] = sw(5'd1, 5'd0, 12'h034);
        r.prog[5] = addi(5'd3, 5'd1, 12'd5);
        r.prog[6] = sw(5'd3, 5'd0, 12'h02c);
        r.prog[7] = EBREAK_INSTR;
        r.exp_addr   = 32'h2c;
        r.exp_value  = sext12(a) + 32'd5;
        r.exp_stores = 8'd1;
        rows[3] = r;
        // row 4 has a bne on equal operands that falls through
        rng = xorshift32(rng);
        a = rng[11:0];
        r = blank_row();
        r.prog[0] = addi(5'd1, 5'd0, a);
        r.prog[1] = addi(5'd2, 5'd0, a);
        r.prog[2] = branch(`CPU_F3_BNE, 5'd1, 5'd2, 13'd12);   // would land on ebreak
        r.prog[3] = addi(5'd3, 5'd1, 12'd7);
        r.prog[4] = sw(5'd3, 5'd0, 12'h030);
        r.prog[5] = EBREAK_INSTR;
        r.exp_addr   = 32'h30;
        r.exp_value  = sext12(a) + 32'd7;
        r.exp_stores = 8'd1;
        rows[4] = r;
        // row 5 checks the jal link while the two slots behind it are squashed
        r = blank_row();
        r.prog[0] = addi(5'd3, 5'd0, 12'd1);
        r.prog[1] = jal(5'd1, 21'd16);                          // pc 4 to 20
        r.prog[2] = sw(5'd3, 5'd0, 12'h03c);
        r.prog[3] = addi(5'd1, 5'd0, 12'd0);
        r.prog[4] = addi(5'd1, 5'd0, 12'd0);
        r.prog[5] = sw(5'd1, 5'd0, 12'h038);
        r.prog[6] = EBREAK_INSTR;
        r.exp_addr   = 32'h38;
        r.exp_value  = 32'd8;
        r.exp_stores = 8'd1;
        rows[5] = r;
    endtask

    task automatic load_memories(input test_row_t row);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < PROG_WORDS) ? row.prog[i] : `CPU_NOP_INSTR;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hd0d0_0000 | (i << 2);     // fill tagged with byte address
        end
        dmem[4] = row.preload;
    endtask

    // ====================
    // main sequence with one table row per pass
    initial begin
        rst_n      = 1'b0;
        test_idx   = 0;
        exp_addr   = '0;
        exp_value  = '0;
        exp_stores = '0;
        build_table();
        load_memories(rows[0]);
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            rst_n      = 1'b0;
            test_idx   = t;
            exp_addr   = rows[t].exp_addr;
            exp_value  = rows[t].exp_value;
            exp_stores = rows[t].exp_stores;
            load_memories(rows[t]);
            repeat (10) @(negedge clk);
            rst_n = 1'b1;
            wait (checked === 1'b1);                // checker saw halt
        end
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIME_LIMIT);
        $display("halt never came, test %0d ran out of time", test_idx);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* testbench/result_checker.sv */
`include "cpu_settings.svh"

module result_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 halt,
    input  logic [`CPU_XLEN-1:0] imem_addr,
    input  logic                 dmem_wr_en,
    input  logic [`CPU_XLEN-1:0] dmem_addr,
    input  logic [`CPU_XLEN-1:0] dmem_wdata,
    input  int                   test_idx,
    input  logic [`CPU_XLEN-1:0] exp_addr,
    input  logic [`CPU_XLEN-1:0] exp_value,
    input  logic [7:0]           exp_stores,
    output logic                 checked,      // verdict printed for this test
    output int                   pass_count,
    output int                   fail_count
);

    int                   stores    = 0;
    logic [`CPU_XLEN-1:0] last_addr = '0;
    logic [`CPU_XLEN-1:0] last_data = '0;
    logic                 reset_bad = 1'b0;    // outputs not idle after reset
    logic                 done_q    = 1'b0;
    int                   passes    = 0;
    int                   fails     = 0;

    assign checked    = done_q;
    assign pass_count = passes;
    assign fail_count = fails;

    // outputs quiet and fetch at address zero the moment reset lets go
    always @(posedge rst_n) begin
        if (halt !== 1'b0 || dmem_wr_en !== 1'b0 || imem_addr !== '0) reset_bad = 1'b1;
    end

    // ====================
    // store log and verdict at halt
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stores    = 0;
            reset_bad = 1'b0;
            done_q    = 1'b0;
        end else if (!done_q) begin
            if (dmem_wr_en) begin
                stores++;
                last_addr = dmem_addr;
                last_data = dmem_wdata;
            end
            if (halt) begin
                done_q = 1'b1;
                if (reset_bad) begin
                    $display("test %0d: halt, dmem_wr_en or imem_addr wrong after reset",
                             test_idx);
                    fails++;
                end else if (stores == 0) begin
                    $display("test %0d: no store seen before halt", test_idx);
                    fails++;
                end else if (last_addr !== exp_addr || last_data !== exp_value) begin
                    $display("mismatch at %0t: test %0d stored %h at %h, expected %h at %h",
                             $time, test_idx, last_data, last_addr, exp_value, exp_addr);
                    fails++;
                end else if (stores != exp_stores) begin
                    $display("mismatch at %0t: test %0d made %0d stores, expected %0d",
                             $time, test_idx, stores, exp_stores);
                    fails++;
                end else begin
                    $display("test %0d: ok, %h at %h", test_idx, last_data, last_addr);
                    passes++;
                end
            end
        end
    end

endmodule

/* hw/riscv_cpu.sv */
`include "cpu_settings.svh"

module riscv_cpu (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0] imem_data,    // combinational, same cycle
    output logic [`CPU_XLEN-1:0] dmem_addr,
    output logic [`CPU_XLEN-1:0] dmem_wdata,
    output logic                 dmem_wr_en,
    input  logic [`CPU_XLEN-1:0] dmem_rdata,   // combinational, same cycle
    output logic                 halt
);

    // f=fetch d=decode e=execute m=memory w=writeback
    logic [`CPU_XLEN-1:0]       pc;
    logic [`CPU_XLEN-1:0]       pc_d;          // fetch->decode pc
    cpu_pkg::instr_u            instr_d;       // fetch->decode instruction
    cpu_pkg::instr_u            instr_dec;     // after flush mux
    cpu_pkg::ctrl_t             ctrl;
    logic [`CPU_REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [`CPU_XLEN-1:0]       imm;
    logic [`CPU_XLEN-1:0]       rs1_data, rs2_data;
    logic [`CPU_XLEN-1:0]       rd_data;       // writeback bus
    cpu_pkg::de_reg_t           de_next, de_q;
    cpu_pkg::em_reg_t           em_next, em_q;
    cpu_pkg::mw_reg_t           mw_next, mw_q;
    cpu_pkg::fwd_sel_e          fwd1_e, fwd2_e;
    logic                       fwd1_d, fwd2_d;
    logic                       flush;
    logic                       redirect;
    logic [`CPU_XLEN-1:0]       target;
    logic [`CPU_XLEN-1:0]       alu_result;
    logic [`CPU_XLEN-1:0]       store_data;
    logic [`CPU_XLEN-1:0]       mem_value;
    logic                       halt_q;        // sticky once ebreak retires

    // ====================
    // fetch
    pc_counter pc_counter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .redirect (redirect),
        .target   (target),
        .pc       (pc)
    );

    assign imem_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_d <= `CPU_NOP_INSTR;
            pc_d    <= '0;
        end else begin
            instr_d <= flush ? `CPU_NOP_INSTR : imem_data;   // kill fetch slot
            pc_d    <= pc;
        end
    end

    // ====================
    // decode
    assign instr_dec = flush ? `CPU_NOP_INSTR : instr_d;       // kill decode slot

    instr_decoder instr_decoder_inst (
        .instr (instr_dec),
        .ctrl  (ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (mw_q.reg_wr),
        .rd       (mw_q.rd),
        .rd_data  (rd_data)
    );

    hazard_unit hazard_unit_inst (
        .rs1_d     (rs1),
        .rs2_d     (rs2),
        .rs1_e     (de_q.rs1),
        .rs2_e     (de_q.rs2),
        .em        (em_q),
        .mw_rd     (mw_q.rd),
        .mw_reg_wr (mw_q.reg_wr),
        .redirect  (redirect),
        .fwd1_e    (fwd1_e),
        .fwd2_e    (fwd2_e),
        .fwd1_d    (fwd1_d),
        .fwd2_d    (fwd2_d),
        .flush     (flush)
    );

    always_comb begin
        de_next.ctrl     = ctrl;
        de_next.pc       = pc_d;
        de_next.rs1_data = fwd1_d ? rd_data : rs1_data;   // same-cycle writeback bypass
        de_next.rs2_data = fwd2_d ? rd_data : rs2_data;
        de_next.imm      = imm;
        de_next.rs1      = rs1;
        de_next.rs2      = rs2;
        de_next.rd       = rd;
    end

    // ====================
    // execute
    execute_unit execute_unit_inst (
        .de         (de_q),
        .fwd1       (fwd1_e),
        .fwd2       (fwd2_e),
        .mem_value  (mem_value),
        .wb_value   (rd_data),
        .alu_result (alu_result),
        .store_data (store_data),
        .redirect   (redirect),
        .target     (target)
    );

    always_comb begin
        em_next.wb_sel     = de_q.ctrl.wb_sel;
        em_next.mem_wr     = de_q.ctrl.mem_wr;
        em_next.reg_wr     = de_q.ctrl.reg_wr;
        em_next.halt       = de_q.ctrl.halt;
        em_next.alu_result = alu_result;
        em_next.store_data = store_data;
        em_next.rd         = de_q.rd;
        em_next.pc_plus_4  = de_q.pc + `CPU_PC_STEP;    // jal link
    end

    // ====================
    // memory
    assign dmem_addr  = em_q.alu_result;
    assign dmem_wdata = em_q.store_data;
    assign dmem_wr_en = em_q.mem_wr;

    // value this stage will retire, fed back to execute
    always_comb begin
        case (em_q.wb_sel)
            cpu_pkg::WB_MEM: mem_value = dmem_rdata;
            cpu_pkg::WB_PC4: mem_value = em_q.pc_plus_4;
            default:         mem_value = em_q.alu_result;
        endcase
    end

    always_comb begin
        mw_next.wb_sel     = em_q.wb_sel;
        mw_next.reg_wr     = em_q.reg_wr;
        mw_next.halt       = em_q.halt;
        mw_next.alu_result = em_q.alu_result;
        mw_next.mem_data   = dmem_rdata;
        mw_next.rd         = em_q.rd;
        mw_next.pc_plus_4  = em_q.pc_plus_4;
    end

    // ====================
    // stage registers, all cleared so nothing retires after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_q   <= '0;
            em_q   <= '0;
            mw_q   <= '0;
            halt_q <= 1'b0;
        end else begin
            de_q   <= de_next;
            em_q   <= em_next;
            mw_q   <= mw_next;
            halt_q <= halt_q | mw_q.halt;
        end
    end

    // ====================
    // writeback
    always_comb begin
        case (mw_q.wb_sel)
            cpu_pkg::WB_MEM: rd_data = mw_q.mem_data;
            cpu_pkg::WB_PC4: rd_data = mw_q.pc_plus_4;
            default:         rd_data = mw_q.alu_result;
        endcase
    end

    assign halt = mw_q.halt | halt_q;   // rises with ebreak in W, then held

endmodule

/* hw/execute_unit.sv */
`include "cpu_settings.svh"

module execute_unit (
    input  cpu_pkg::de_reg_t        de,
    input  cpu_pkg::fwd_sel_e       fwd1,
    input  cpu_pkg::fwd_sel_e       fwd2,
    input  logic [`CPU_XLEN-1:0]    mem_value,    // what the M stage will write back
    input  logic [`CPU_XLEN-1:0]    wb_value,
    output logic [`CPU_XLEN-1:0]    alu_result,
    output logic [`CPU_XLEN-1:0]    store_data,
    output logic                    redirect,
    output logic [`CPU_XLEN-1:0]    target
);

    logic [`CPU_XLEN-1:0] op_a;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] rs2_val;    // forwarded rs2, also the store data
    logic                 zero;
    logic                 less_than;

    // ====================
    // forwarding muxes
    always_comb begin
        case (fwd1)
            cpu_pkg::FWD_MEM: op_a = mem_value;
            cpu_pkg::FWD_WB:  op_a = wb_value;
            default:          op_a = de.rs1_data;
        endcase
        case (fwd2)
            cpu_pkg::FWD_MEM: rs2_val = mem_value;
            cpu_pkg::FWD_WB:  rs2_val = wb_value;
            default:          rs2_val = de.rs2_data;
        endcase
    end

    assign op_b       = de.ctrl.use_imm ? de.imm : rs2_val;
    assign store_data = rs2_val;

    // ====================
    // alu
    assign less_than = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (de.ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_result = op_a + op_b;
            cpu_pkg::ALU_SUB: alu_result = op_a - op_b;
            cpu_pkg::ALU_AND: alu_result = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_result = op_a | op_b;
            cpu_pkg::ALU_XOR: alu_result = op_a ^ op_b;
            cpu_pkg::ALU_SLT: alu_result = {{(`CPU_XLEN-1){1'b0}}, less_than};
            default:          alu_result = '0;
        endcase
    end

    assign zero = (alu_result == '0);    // branches run a sub

    // branch / jump decision, target is pc relative for all three
    assign redirect = (de.ctrl.branch_eq && zero) ||
                      (de.ctrl.branch_ne && !zero) ||
                      de.ctrl.jump;
    assign target   = de.pc + de.imm;

endmodule

/* hw/hazard_unit.sv */
`include "cpu_settings.svh"

module hazard_unit (
    input  logic [`CPU_REG_ADDR_W-1:0]  rs1_d,
    input  logic [`CPU_REG_ADDR_W-1:0]  rs2_d,
    input  logic [`CPU_REG_ADDR_W-1:0]  rs1_e,
    input  logic [`CPU_REG_ADDR_W-1:0]  rs2_e,
    input  cpu_pkg::em_reg_t            em,
    input  logic [`CPU_REG_ADDR_W-1:0]  mw_rd,
    input  logic                        mw_reg_wr,
    input  logic                        redirect,
    output cpu_pkg::fwd_sel_e           fwd1_e,
    output cpu_pkg::fwd_sel_e           fwd2_e,
    output logic                        fwd1_d,
    output logic                        fwd2_d,
    output logic                        flush
);

    // a live producer writing the register being read
    function automatic logic hit(input logic wr,
                                 input logic [`CPU_REG_ADDR_W-1:0] dst,
                                 input logic [`CPU_REG_ADDR_W-1:0] src);
        return wr && (dst != '0) && (dst == src);
    endfunction

    // execute operands, younger producer in memory wins
    always_comb begin
        fwd1_e = cpu_pkg::FWD_NONE;
        fwd2_e = cpu_pkg::FWD_NONE;
        if (hit(em.reg_wr, em.rd, rs1_e))      fwd1_e = cpu_pkg::FWD_MEM;
        else if (hit(mw_reg_wr, mw_rd, rs1_e)) fwd1_e = cpu_pkg::FWD_WB;
        if (hit(em.reg_wr, em.rd, rs2_e))      fwd2_e = cpu_pkg::FWD_MEM;
        else if (hit(mw_reg_wr, mw_rd, rs2_e)) fwd2_e = cpu_pkg::FWD_WB;
    end

    // decode read racing the writeback write in the same cycle
    assign fwd1_d = hit(mw_reg_wr, mw_rd, rs1_d);
    assign fwd2_d = hit(mw_reg_wr, mw_rd, rs2_d);

    assign flush = redirect;   // kill fetch and decode slots

endmodule

/* hw/reg_file.sv */
`include "cpu_settings.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CPU_REG_ADDR_W-1:0]  rs1,
    input  logic [`CPU_REG_ADDR_W-1:0]  rs2,
    output logic [`CPU_XLEN-1:0]        rs1_data,
    output logic [`CPU_XLEN-1:0]        rs2_data,
    input  logic                        wr_en,
    input  logic [`CPU_REG_ADDR_W-1:0]  rd,
    input  logic [`CPU_XLEN-1:0]        rd_data
);

    logic [`CPU_XLEN-1:0] regs [1:`CPU_REG_COUNT-1];   // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (rd != '0)) begin
            regs[rd] <= rd_data;       // writes to x0 dropped
        end
    end

    // combinational read ports
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/instr_decoder.sv */
`include "cpu_settings.svh"

module instr_decoder (
    input  cpu_pkg::instr_u             instr,
    output cpu_pkg::ctrl_t              ctrl,
    output logic [`CPU_REG_ADDR_W-1:0]  rs1,
    output logic [`CPU_REG_ADDR_W-1:0]  rs2,
    output logic [`CPU_REG_ADDR_W-1:0]  rd,
    output logic [`CPU_XLEN-1:0]        imm
);

    // register fields sit at the same bits in every format
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    always_comb begin
        ctrl = '0;                      // unknown opcode -> nop
        imm  = '0;
        case (instr.r.opcode)
            `CPU_OP_REG: begin
                ctrl.reg_wr = 1'b1;
                case (instr.r.funct3)
                    `CPU_F3_ADD: ctrl.alu_op = (instr.r.funct7 == `CPU_F7_SUB) ?
                                               cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    `CPU_F3_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
                    `CPU_F3_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    `CPU_F3_XOR: ctrl.alu_op = cpu_pkg::ALU_XOR;
                    `CPU_F3_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
                    default:     ctrl.reg_wr = 1'b0;   // shifts, sltu not built
                endcase
            end
            `CPU_OP_IMM: begin
                imm          = {{20{instr.i.imm[11]}}, instr.i.imm};
                ctrl.use_imm = 1'b1;
                ctrl.reg_wr  = (instr.i.funct3 == `CPU_F3_ADD);   // addi only
            end
            `CPU_OP_LOAD: begin
                imm          = {{20{instr.i.imm[11]}}, instr.i.imm};
                ctrl.use_imm = 1'b1;            // address = rs1 + imm
                ctrl.wb_sel  = cpu_pkg::WB_MEM;
                ctrl.reg_wr  = (instr.i.funct3 == `CPU_F3_WORD);
            end
            `CPU_OP_STORE: begin
                imm          = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                ctrl.use_imm = 1'b1;
                ctrl.mem_wr  = (instr.s.funct3 == `CPU_F3_WORD);
            end
            `CPU_OP_BRANCH: begin
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
                ctrl.alu_op    = cpu_pkg::ALU_SUB;    // zero flag means equal
                ctrl.branch_eq = (instr.b.funct3 == `CPU_F3_BEQ);
                ctrl.branch_ne = (instr.b.funct3 == `CPU_F3_BNE);
            end
            `CPU_OP_JAL: begin
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
                ctrl.jump   = 1'b1;
                ctrl.wb_sel = cpu_pkg::WB_PC4;        // link address
                ctrl.reg_wr = 1'b1;
            end
            `CPU_OP_SYSTEM: begin
                // ebreak is imm 1, funct3 0, all else zero
                ctrl.halt = (instr.i.imm == 12'd1) && (instr.i.funct3 == 3'b000);
            end
            default: ;
        endcase
    end

endmodule

/* hw/pc_counter.sv */
`include "cpu_settings.svh"

module pc_counter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 redirect,   // taken branch or jump in execute
    input  logic [`CPU_XLEN-1:0] target,
    output logic [`CPU_XLEN-1:0] pc
);

    // next pc: sequential step unless execute redirects
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CPU_RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else begin
            pc <= pc + `CPU_PC_STEP;
        end
    end

endmodule

/* hw/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

    // ====================
    // instruction formats, all views of one 32 bit word

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [6:0]                 opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [6:0]                 opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]                 imm_hi;   // imm[11:5]
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 imm_lo;   // imm[4:0]
        logic [6:0]                 opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                       imm12;
        logic [5:0]                 imm10_5;
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [2:0]                 funct3;
        logic [3:0]                 imm4_1;
        logic                       imm11;
        logic [6:0]                 opcode;
    } b_fmt_t;

    typedef struct packed {
        logic                       imm20;
        logic [9:0]                 imm10_1;
        logic                       imm11;
        logic [7:0]                 imm19_12;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [6:0]                 opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
    } instr_u;

    // ====================
    // control encodings, zero values give a harmless nop

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_NONE, FWD_MEM, FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;     // operand b from immediate
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    mem_wr;
        wb_sel_e wb_sel;
        logic    reg_wr;
        logic    halt;        // ebreak marker
    } ctrl_t;

    // ====================
    // stage registers

    typedef struct packed {
        ctrl_t                      ctrl;
        logic [`CPU_XLEN-1:0]       pc;
        logic [`CPU_XLEN-1:0]       rs1_data;
        logic [`CPU_XLEN-1:0]       rs2_data;
        logic [`CPU_XLEN-1:0]       imm;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_REG_ADDR_W-1:0] rd;
    } de_reg_t;

    typedef struct packed {
        wb_sel_e                    wb_sel;
        logic                       mem_wr;
        logic                       reg_wr;
        logic                       halt;
        logic [`CPU_XLEN-1:0]       alu_result;
        logic [`CPU_XLEN-1:0]       store_data;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [`CPU_XLEN-1:0]       pc_plus_4;
    } em_reg_t;

    typedef struct packed {
        wb_sel_e                    wb_sel;
        logic                       reg_wr;
        logic                       halt;
        logic [`CPU_XLEN-1:0]       alu_result;
        logic [`CPU_XLEN-1:0]       mem_data;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [`CPU_XLEN-1:0]       pc_plus_4;
    } mw_reg_t;

endpackage

/* hw/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// machine widths, fixed by rv32i
`define CPU_XLEN        32
`define CPU_REG_COUNT   32
`define CPU_REG_ADDR_W  5
`define CPU_PC_STEP     32'd4
`define CPU_RESET_PC    32'h0000_0000
`define CPU_NOP_INSTR   32'h0000_0013   // addi x0, x0, 0

// major opcodes
`define CPU_OP_REG      7'b0110011
`define CPU_OP_IMM      7'b0010011
`define CPU_OP_LOAD     7'b0000011
`define CPU_OP_STORE    7'b0100011
`define CPU_OP_BRANCH   7'b1100011
`define CPU_OP_JAL      7'b1101111
`define CPU_OP_SYSTEM   7'b1110011

// funct3 / funct7 codes
`define CPU_F3_ADD      3'b000  // add, sub, addi
`define CPU_F3_AND      3'b111
`define CPU_F3_OR       3'b110
`define CPU_F3_XOR      3'b100
`define CPU_F3_SLT      3'b010
`define CPU_F3_WORD     3'b010  // lw, sw
`define CPU_F3_BEQ      3'b000
`define CPU_F3_BNE      3'b001
`define CPU_F7_SUB      7'b0100000

`endif
